// File: source/ad7124_pkg.sv
package ad7124_pkg;

    // Microprocessor register bus
    typedef logic [13:0] up_addr_t;
    typedef logic [31:0] up_data_t;

    // One byte clocked in from a converter
    typedef logic [7:0] sample_byte_t;

    // External BRAM write port
    typedef logic [12:0] bram_addr_t;
    typedef logic [31:0] bram_data_t;

    // Words requested per acquisition run
    typedef logic [7:0] word_count_t;

    // Channel number sits above this bit, register offset below it
    localparam int CHANNEL_ADDR_SHIFT = 7;

    typedef logic [CHANNEL_ADDR_SHIFT-1:0] reg_offset_t;

    localparam reg_offset_t REG_WORD_COUNT   = 'd0;
    localparam reg_offset_t REG_START_STATUS = 'd1;

endpackage

// File: source/sample_stream_if.sv
interface sample_stream_if import ad7124_pkg::*; ();

    logic         valid;
    logic         ready;
    sample_byte_t data;

    // Reader side
    modport source (
        output valid,
        output data,
        input  ready
    );

    // FIFO side
    modport sink (
        input  valid,
        input  data,
        output ready
    );

endinterface

// File: source/ad7124_regmap.sv
module ad7124_regmap import ad7124_pkg::*; #(
    parameter int NUM_OF_BOARD = 2
) (
    input  logic                    aclk,
    input  logic                    rst_n_i,
    input  logic                    up_wreq_i,
    input  up_addr_t                up_waddr_i,
    input  up_data_t                up_wdata_i,
    output logic                    up_wack_o,
    input  logic                    up_rreq_i,
    input  up_addr_t                up_raddr_i,
    output up_data_t                up_rdata_o,
    output logic                    up_rack_o,
    output logic [NUM_OF_BOARD-1:0] start_o,
    output word_count_t             word_count_o [NUM_OF_BOARD],
    input  logic [NUM_OF_BOARD-1:0] busy_i
);

    localparam int SEL_W = $bits(up_addr_t) - CHANNEL_ADDR_SHIFT;

    logic [SEL_W-1:0] wr_channel;
    logic [SEL_W-1:0] rd_channel;
    reg_offset_t      wr_reg;
    reg_offset_t      rd_reg;

    assign wr_channel = up_waddr_i[$bits(up_addr_t)-1:CHANNEL_ADDR_SHIFT];
    assign wr_reg     = up_waddr_i[CHANNEL_ADDR_SHIFT-1:0];
    assign rd_channel = up_raddr_i[$bits(up_addr_t)-1:CHANNEL_ADDR_SHIFT];
    assign rd_reg     = up_raddr_i[CHANNEL_ADDR_SHIFT-1:0];

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            up_wack_o <= 1'b0;
            up_rack_o <= 1'b0;
            start_o   <= '0;
            for (int i = 0; i < NUM_OF_BOARD; i++) begin
                word_count_o[i] <= '0;
            end
        end else begin
            up_wack_o <= up_wreq_i;
            up_rack_o <= up_rreq_i;
            start_o   <= '0;
            for (int i = 0; i < NUM_OF_BOARD; i++) begin
                if (up_wreq_i && wr_channel == SEL_W'(i)) begin
                    if (wr_reg == REG_WORD_COUNT) begin
                        word_count_o[i] <= up_wdata_i[$bits(word_count_t)-1:0];
                    end
                    // A start into a running channel is dropped
                    if (wr_reg == REG_START_STATUS && up_wdata_i[0] &&
                        !busy_i[i] && !start_o[i]) begin
                        start_o[i] <= 1'b1;
                    end
                end
            end
        end
    end

    // Unmapped channels and offsets read as zero
    always_ff @(posedge aclk) begin
        up_rdata_o <= '0;
        for (int i = 0; i < NUM_OF_BOARD; i++) begin
            if (rd_channel == SEL_W'(i)) begin
                if (rd_reg == REG_WORD_COUNT) begin
                    up_rdata_o <= up_data_t'(word_count_o[i]);
                end else if (rd_reg == REG_START_STATUS) begin
                    up_rdata_o <= up_data_t'(busy_i[i]);
                end
            end
        end
    end

endmodule

// File: source/ad7124_spi_reader.sv
module ad7124_spi_reader import ad7124_pkg::*; #(
    parameter int SCLK_DIV = 2
) (
    input  logic            aclk,
    input  logic            rst_n_i,
    input  logic            start_i,
    input  word_count_t     word_count_i,
    output logic            busy_o,
    output logic            sclk_o,
    output logic            csn_o,
    input  logic            miso_i,
    sample_stream_if.source out
);

    localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_OFFER,
        ST_DONE
    } state_t;

    state_t                         state;
    logic [DIV_W-1:0]               div_cnt;
    logic                           div_done;
    logic                           rise;
    logic [2:0]                     bit_cnt;
    logic [$bits(word_count_t)+1:0] bytes_left;
    logic [6:0]                     shift_q;

    assign div_done = div_cnt == DIV_W'(SCLK_DIV - 1);
    // SCLK is low and about to go high, so MISO is sampled now
    assign rise     = state == ST_SHIFT && div_done && !sclk_o;
    assign busy_o   = state != ST_IDLE;

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            state      <= ST_IDLE;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            bytes_left <= '0;
            sclk_o     <= 1'b1;
            csn_o      <= 1'b1;
            out.valid  <= 1'b0;
        end else begin
            if (out.valid && out.ready) begin
                out.valid <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (start_i && word_count_i != '0) begin
                        csn_o      <= 1'b0;
                        div_cnt    <= '0;
                        bit_cnt    <= '0;
                        bytes_left <= {word_count_i, 2'b00};
                        state      <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    div_cnt <= div_done ? '0 : div_cnt + 1'b1;
                    if (div_done) begin
                        sclk_o <= !sclk_o;
                    end
                    if (rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            out.valid  <= 1'b1;
                            bytes_left <= bytes_left - 1'b1;
                            state      <= (bytes_left == 'd1) ? ST_DONE : ST_OFFER;
                        end
                    end
                end
                ST_OFFER: begin
                    // Hold SCLK high until the previous byte has gone
                    if (!div_done) begin
                        div_cnt <= div_cnt + 1'b1;
                    end else if (!out.valid || out.ready) begin
                        div_cnt <= '0;
                        sclk_o  <= 1'b0;
                        state   <= ST_SHIFT;
                    end
                end
                ST_DONE: begin
                    if (out.valid && out.ready) begin
                        csn_o <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (rise) begin
            shift_q <= {shift_q[5:0], miso_i};
            if (bit_cnt == 3'd7) begin
                out.data <= {shift_q, miso_i};
            end
        end
    end

endmodule

// File: source/sample_fifo.sv
module sample_fifo import ad7124_pkg::*; #(
    parameter  int NUM_OF_BOARD    = 2,
    parameter  int FIFO_DEPTH_LOG2 = 4,
    localparam int CH_W            = (NUM_OF_BOARD > 1) ? $clog2(NUM_OF_BOARD) : 1
) (
    input  logic            aclk,
    input  logic            rst_n_i,
    sample_stream_if.sink   in [NUM_OF_BOARD],
    output logic            empty_o,
    input  logic            rd_i,
    output sample_byte_t    rd_data_o,
    output logic [CH_W-1:0] rd_channel_o
);

    localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

    logic [NUM_OF_BOARD-1:0]    in_valid;
    logic [NUM_OF_BOARD-1:0]    grant;
    sample_byte_t               in_data [NUM_OF_BOARD];
    logic [CH_W-1:0]            sel;
    sample_byte_t               data_mem [DEPTH];
    logic [CH_W-1:0]            channel_mem [DEPTH];
    logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
    logic [FIFO_DEPTH_LOG2:0]   count;
    logic                       full;
    logic                       push;
    logic                       pop;

    for (genvar i = 0; i < NUM_OF_BOARD; i++) begin : g_in
        assign in_valid[i] = in[i].valid;
        assign in_data[i]  = in[i].data;
        assign in[i].ready = grant[i] && !full;
    end

    // Lowest numbered requester wins
    always_comb begin
        grant = '0;
        sel   = '0;
        for (int i = NUM_OF_BOARD - 1; i >= 0; i--) begin
            if (in_valid[i]) begin
                grant    = '0;
                grant[i] = 1'b1;
                sel      = CH_W'(i);
            end
        end
    end

    // Top bit of the count is set only when every slot is taken
    assign full    = count[FIFO_DEPTH_LOG2];
    assign empty_o = count == '0;
    assign push    = |grant && !full;
    assign pop     = rd_i && !empty_o;

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            data_mem[wr_ptr]    <= in_data[sel];
            channel_mem[wr_ptr] <= sel;
        end
    end

    assign rd_data_o    = data_mem[rd_ptr];
    assign rd_channel_o = channel_mem[rd_ptr];

endmodule

// File: source/bram_packer.sv
module bram_packer import ad7124_pkg::*; #(
    parameter  int NUM_OF_BOARD           = 2,
    parameter  int WORDS_PER_CHANNEL_LOG2 = 5,
    localparam int CH_W = (NUM_OF_BOARD > 1) ? $clog2(NUM_OF_BOARD) : 1
) (
    input  logic                    aclk,
    input  logic                    rst_n_i,
    input  logic                    empty_i,
    output logic                    rd_o,
    input  sample_byte_t            rd_data_i,
    input  logic [CH_W-1:0]         rd_channel_i,
    input  logic [NUM_OF_BOARD-1:0] start_i,
    output logic                    bram_en_o,
    output logic [3:0]              bram_we_o,
    output bram_addr_t              bram_addr_o,
    output bram_data_t              bram_wrdata_o
);

    // Per channel state so that bytes of different channels may interleave
    logic [1:0]                        byte_cnt [NUM_OF_BOARD];
    logic [23:0]                       acc      [NUM_OF_BOARD];
    logic [WORDS_PER_CHANNEL_LOG2-1:0] word_idx [NUM_OF_BOARD];
    logic                              word_done;

    assign rd_o      = !empty_i;
    assign word_done = rd_o && byte_cnt[rd_channel_i] == 2'd3;

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            bram_en_o <= 1'b0;
            bram_we_o <= '0;
            for (int i = 0; i < NUM_OF_BOARD; i++) begin
                byte_cnt[i] <= '0;
                word_idx[i] <= '0;
            end
        end else begin
            bram_en_o <= word_done;
            bram_we_o <= {4{word_done}};
            if (rd_o) begin
                byte_cnt[rd_channel_i] <= byte_cnt[rd_channel_i] + 1'b1;
            end
            if (word_done) begin
                word_idx[rd_channel_i] <= word_idx[rd_channel_i] + 1'b1;
            end
            for (int i = 0; i < NUM_OF_BOARD; i++) begin
                if (start_i[i]) begin
                    word_idx[i] <= '0;
                end
            end
        end
    end

    // First byte of a word ends up in the top bits
    always_ff @(posedge aclk) begin
        if (rd_o) begin
            acc[rd_channel_i] <= {acc[rd_channel_i][15:0], rd_data_i};
        end
        if (word_done) begin
            bram_wrdata_o <= {acc[rd_channel_i], rd_data_i};
            bram_addr_o   <= bram_addr_t'({rd_channel_i, word_idx[rd_channel_i]});
        end
    end

endmodule

// File: source/ad7124_acq_top.sv
module ad7124_acq_top import ad7124_pkg::*; #(
    parameter int NUM_OF_BOARD           = 2,
    parameter int SCLK_DIV               = 2,
    parameter int FIFO_DEPTH_LOG2        = 4,
    parameter int WORDS_PER_CHANNEL_LOG2 = 5
) (
    input  logic                    aclk,
    input  logic                    rst_n_i,
    // Microprocessor register bus
    input  logic                    up_wreq_i,
    input  up_addr_t                up_waddr_i,
    input  up_data_t                up_wdata_i,
    output logic                    up_wack_o,
    input  logic                    up_rreq_i,
    input  up_addr_t                up_raddr_i,
    output up_data_t                up_rdata_o,
    output logic                    up_rack_o,
    // One SPI link per converter
    output logic [NUM_OF_BOARD-1:0] spi_sclk_o,
    output logic [NUM_OF_BOARD-1:0] spi_csn_o,
    input  logic [NUM_OF_BOARD-1:0] spi_miso_i,
    // BRAM write port
    output logic                    bram_en_o,
    output logic [3:0]              bram_we_o,
    output bram_addr_t              bram_addr_o,
    output bram_data_t              bram_wrdata_o
);

    localparam int CH_W = (NUM_OF_BOARD > 1) ? $clog2(NUM_OF_BOARD) : 1;

    logic [NUM_OF_BOARD-1:0] start;
    logic [NUM_OF_BOARD-1:0] busy;
    word_count_t             word_count [NUM_OF_BOARD];
    logic                    fifo_empty;
    logic                    fifo_rd;
    sample_byte_t            fifo_data;
    logic [CH_W-1:0]         fifo_channel;

    sample_stream_if stream [NUM_OF_BOARD] ();

    ad7124_regmap #(
        .NUM_OF_BOARD(NUM_OF_BOARD)
    ) i_ad7124_regmap (
        .aclk        (aclk      ),
        .rst_n_i     (rst_n_i   ),
        .up_wreq_i   (up_wreq_i ),
        .up_waddr_i  (up_waddr_i),
        .up_wdata_i  (up_wdata_i),
        .up_wack_o   (up_wack_o ),
        .up_rreq_i   (up_rreq_i ),
        .up_raddr_i  (up_raddr_i),
        .up_rdata_o  (up_rdata_o),
        .up_rack_o   (up_rack_o ),
        .start_o     (start     ),
        .word_count_o(word_count),
        .busy_i      (busy      )
    );

    for (genvar i = 0; i < NUM_OF_BOARD; i++) begin : g_reader
        ad7124_spi_reader #(
            .SCLK_DIV(SCLK_DIV)
        ) i_ad7124_spi_reader (
            .aclk        (aclk         ),
            .rst_n_i     (rst_n_i      ),
            .start_i     (start[i]     ),
            .word_count_i(word_count[i]),
            .busy_o      (busy[i]      ),
            .sclk_o      (spi_sclk_o[i]),
            .csn_o       (spi_csn_o[i] ),
            .miso_i      (spi_miso_i[i]),
            .out         (stream[i]    )
        );
    end

    sample_fifo #(
        .NUM_OF_BOARD   (NUM_OF_BOARD   ),
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
    ) i_sample_fifo (
        .aclk        (aclk        ),
        .rst_n_i     (rst_n_i     ),
        .in          (stream      ),
        .empty_o     (fifo_empty  ),
        .rd_i        (fifo_rd     ),
        .rd_data_o   (fifo_data   ),
        .rd_channel_o(fifo_channel)
    );

    bram_packer #(
        .NUM_OF_BOARD          (NUM_OF_BOARD          ),
        .WORDS_PER_CHANNEL_LOG2(WORDS_PER_CHANNEL_LOG2)
    ) i_bram_packer (
        .aclk         (aclk         ),
        .rst_n_i      (rst_n_i      ),
        .empty_i      (fifo_empty   ),
        .rd_o         (fifo_rd      ),
        .rd_data_i    (fifo_data    ),
        .rd_channel_i (fifo_channel ),
        .start_i      (start        ),
        .bram_en_o    (bram_en_o    ),
        .bram_we_o    (bram_we_o    ),
        .bram_addr_o  (bram_addr_o  ),
        .bram_wrdata_o(bram_wrdata_o)
    );

endmodule

// File: bench/tb_clock.sv
module tb_clock #(
    parameter int PERIOD_NS = 10
) (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 100ps;

    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2) clk_o = !clk_o;

endmodule

// File: bench/tb_bram_checker.sv
module tb_bram_checker import ad7124_pkg::*; #(
    parameter int          NUM_OF_BOARD           = 2,
    parameter int          WORDS_PER_CHANNEL_LOG2 = 5,
    parameter logic [31:0] SEED                   = 32'h66d7_fd77
) (
    input  logic                    aclk,
    input  logic                    rst_n_i,
    input  logic [NUM_OF_BOARD-1:0] spi_csn_i,
    input  logic                    bram_en_i,
    input  logic [3:0]              bram_we_i,
    input  bram_addr_t              bram_addr_i,
    input  bram_data_t              bram_wrdata_i,
    output int                      writes_o [NUM_OF_BOARD],
    output int                      errors_o
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int REGION_WORDS = 2 ** WORDS_PER_CHANNEL_LOG2;

    logic [31:0]             rng      [NUM_OF_BOARD];
    int                      next_idx [NUM_OF_BOARD];
    logic [NUM_OF_BOARD-1:0] csn_q;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Same per-channel byte streams as the converter models
    initial begin
        errors_o = 0;
        csn_q    = '1;
        for (int c = 0; c < NUM_OF_BOARD; c++) begin
            rng[c]      = SEED ^ (32'(c) * 32'h9e37_79b9);
            next_idx[c] = 0;
            writes_o[c] = 0;
        end
    end

    always @(negedge aclk) begin
        int         ch;
        int         idx;
        bram_data_t expected;
        if (rst_n_i) begin
            // A new run begins at the channel base
            for (int c = 0; c < NUM_OF_BOARD; c++) begin
                if (csn_q[c] && !spi_csn_i[c]) begin
                    next_idx[c] = 0;
                end
            end
            csn_q = spi_csn_i;
            if (bram_en_i) begin
                ch  = int'(bram_addr_i >> WORDS_PER_CHANNEL_LOG2);
                idx = int'(bram_addr_i[WORDS_PER_CHANNEL_LOG2-1:0]);
                if (bram_we_i !== 4'hf) begin
                    errors_o++;
                    $display("Error at %0t ns: write enables 0x%0h, expected 0xf",
                             $time, bram_we_i);
                end
                if (ch >= NUM_OF_BOARD) begin
                    errors_o++;
                    $display("Error at %0t ns: BRAM address 0x%0h lies outside every region",
                             $time, bram_addr_i);
                end else begin
                    expected = '0;
                    for (int k = 0; k < 4; k++) begin
                        rng[ch]  = xorshift32(rng[ch]);
                        expected = {expected[23:0], rng[ch][7:0]};
                    end
                    if (idx != next_idx[ch]) begin
                        errors_o++;
                        $display("Error at %0t ns: channel %0d wrote index %0d, expected %0d",
                                 $time, ch, idx, next_idx[ch]);
                    end
                    if (bram_wrdata_i !== expected) begin
                        errors_o++;
                        $display("Error at %0t ns: channel %0d word 0x%08h, expected 0x%08h",
                                 $time, ch, bram_wrdata_i, expected);
                    end
                    next_idx[ch] = (next_idx[ch] + 1) % REGION_WORDS;
                    writes_o[ch]++;
                end
            end else if (bram_we_i !== 4'h0) begin
                errors_o++;
                $display("Error at %0t ns: write enables 0x%0h without a BRAM enable",
                         $time, bram_we_i);
            end
        end
    end

endmodule

// File: bench/tb_ad7124_acq.sv
module tb_ad7124_acq import ad7124_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NUM_OF_BOARD           = 2;
    localparam int          SCLK_DIV               = 2;
    localparam int          FIFO_DEPTH_LOG2        = 4;
    localparam int          WORDS_PER_CHANNEL_LOG2 = 5;
    localparam logic [31:0] SEED                   = 32'h66d7_fd77;
    localparam int          RESET_CYCLES           = 10;
    localparam int          SETTLE_CYCLES          = 100;
    localparam int          NUM_STEPS              = 3;

    // Words per channel in each step where 0 leaves that channel idle
    localparam int STEP_WORDS [NUM_STEPS][NUM_OF_BOARD] = '{'{3, 0}, '{2, 5}, '{0, 3}};
    // Channel that gets a second start while busy or -1 for none
    localparam int STEP_RESEND [NUM_STEPS] = '{-1, -1, 1};

    logic                    aclk;
    logic                    rst_n;
    logic                    up_wreq;
    up_addr_t                up_waddr;
    up_data_t                up_wdata;
    logic                    up_wack;
    logic                    up_rreq;
    up_addr_t                up_raddr;
    up_data_t                up_rdata;
    logic                    up_rack;
    logic [NUM_OF_BOARD-1:0] spi_sclk;
    logic [NUM_OF_BOARD-1:0] spi_csn;
    logic [NUM_OF_BOARD-1:0] spi_miso;
    logic                    bram_en;
    logic [3:0]              bram_we;
    bram_addr_t              bram_addr;
    bram_data_t              bram_wrdata;
    int                      writes [NUM_OF_BOARD];
    int                      checker_errors;
    int                      target [NUM_OF_BOARD];
    int                      checks = 0;
    int                      errors = 0;
    int                      cycles = 0;
    int                      timeout_cycles;

    tb_clock clock_i (
        .clk_o(aclk)
    );

    ad7124_acq_top #(
        .NUM_OF_BOARD          (NUM_OF_BOARD          ),
        .SCLK_DIV              (SCLK_DIV              ),
        .FIFO_DEPTH_LOG2       (FIFO_DEPTH_LOG2       ),
        .WORDS_PER_CHANNEL_LOG2(WORDS_PER_CHANNEL_LOG2)
    ) ad7124_acq_top_i (
        .aclk         (aclk       ),
        .rst_n_i      (rst_n      ),
        .up_wreq_i    (up_wreq    ),
        .up_waddr_i   (up_waddr   ),
        .up_wdata_i   (up_wdata   ),
        .up_wack_o    (up_wack    ),
        .up_rreq_i    (up_rreq    ),
        .up_raddr_i   (up_raddr   ),
        .up_rdata_o   (up_rdata   ),
        .up_rack_o    (up_rack    ),
        .spi_sclk_o   (spi_sclk   ),
        .spi_csn_o    (spi_csn    ),
        .spi_miso_i   (spi_miso   ),
        .bram_en_o    (bram_en    ),
        .bram_we_o    (bram_we    ),
        .bram_addr_o  (bram_addr  ),
        .bram_wrdata_o(bram_wrdata)
    );

    tb_bram_checker #(
        .NUM_OF_BOARD          (NUM_OF_BOARD          ),
        .WORDS_PER_CHANNEL_LOG2(WORDS_PER_CHANNEL_LOG2),
        .SEED                  (SEED                  )
    ) bram_checker_i (
        .aclk         (aclk          ),
        .rst_n_i      (rst_n         ),
        .spi_csn_i    (spi_csn       ),
        .bram_en_i    (bram_en       ),
        .bram_we_i    (bram_we       ),
        .bram_addr_i  (bram_addr     ),
        .bram_wrdata_i(bram_wrdata   ),
        .writes_o     (writes        ),
        .errors_o     (checker_errors)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Mode 3 converters shift each bit out on the falling SCLK edge
    for (genvar c = 0; c < NUM_OF_BOARD; c++) begin : g_converter
        logic [31:0] rng     = SEED ^ (32'(c) * 32'h9e37_79b9);
        logic [7:0]  shift   = 8'h00;
        int          bit_idx = 0;
        logic        miso    = 1'b0;

        assign spi_miso[c] = miso;

        always @(negedge spi_sclk[c]) begin
            if (!spi_csn[c]) begin
                if (bit_idx == 0) begin
                    rng   = xorshift32(rng);
                    shift = rng[7:0];
                end
                miso    <= shift[7];
                shift   = {shift[6:0], 1'b0};
                bit_idx = (bit_idx + 1) % 8;
            end
        end
    end

    function automatic up_addr_t reg_addr(input int ch, input reg_offset_t offset);
        return up_addr_t'((ch << CHANNEL_ADDR_SHIFT) + int'(offset));
    endfunction

    function automatic int run_limit();
        int total = 0;
        for (int s = 0; s < NUM_STEPS; s++) begin
            for (int c = 0; c < NUM_OF_BOARD; c++) begin
                total += STEP_WORDS[s][c] * 32 * 2 * SCLK_DIV;
            end
        end
        return total + 2000;
    endfunction

    function automatic bit all_written();
        for (int c = 0; c < NUM_OF_BOARD; c++) begin
            if (writes[c] < target[c]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
        end
    endtask

    task automatic bus_write(input up_addr_t addr, input up_data_t data);
        up_wreq  = 1'b1;
        up_waddr = addr;
        up_wdata = data;
        @(negedge aclk);
        up_wreq = 1'b0;
        check_value("write ack", 32'(up_wack), 32'd1);
        @(negedge aclk);
        check_value("write ack release", 32'(up_wack), 32'd0);
    endtask

    task automatic bus_read(input up_addr_t addr, output up_data_t data);
        up_rreq  = 1'b1;
        up_raddr = addr;
        @(negedge aclk);
        up_rreq = 1'b0;
        check_value("read ack", 32'(up_rack), 32'd1);
        data = up_rdata;
        @(negedge aclk);
        check_value("read ack release", 32'(up_rack), 32'd0);
    endtask

    task automatic check_lines(input int ch, input logic csn_expected);
        check_value($sformatf("csn[%0d]", ch), 32'(spi_csn[ch]), 32'(csn_expected));
        if (csn_expected) begin
            check_value($sformatf("sclk[%0d]", ch), 32'(spi_sclk[ch]), 32'd1);
        end
    endtask

    task automatic check_quiet_after_reset();
        repeat (50) begin
            @(negedge aclk);
            for (int c = 0; c < NUM_OF_BOARD; c++) begin
                check_lines(c, 1'b1);
            end
        end
        for (int c = 0; c < NUM_OF_BOARD; c++) begin
            check_value("writes before any start", writes[c], 0);
        end
    endtask

    task automatic check_register_access();
        up_data_t data;
        // Only the low byte of the word count is kept
        for (int c = 0; c < NUM_OF_BOARD; c++) begin
            bus_write(reg_addr(c, REG_WORD_COUNT), 32'h1234_5600 | 32'(c + 9));
            bus_read(reg_addr(c, REG_WORD_COUNT), data);
            check_value("word count read-back", data, 32'(c + 9));
            bus_read(reg_addr(c, REG_START_STATUS), data);
            check_value("idle status", data, 32'd0);
        end
        bus_write(reg_addr(NUM_OF_BOARD, REG_WORD_COUNT), 32'h55);
        bus_read(reg_addr(NUM_OF_BOARD, REG_WORD_COUNT), data);
        check_value("unused channel", data, 32'd0);
        bus_read(reg_addr(0, reg_offset_t'(2)), data);
        check_value("unused offset", data, 32'd0);
    endtask

    task automatic run_step(input int s);
        up_data_t data;
        int       base_writes;
        for (int c = 0; c < NUM_OF_BOARD; c++) begin
            if (STEP_WORDS[s][c] != 0) begin
                bus_write(reg_addr(c, REG_WORD_COUNT), 32'(STEP_WORDS[s][c]));
                bus_read(reg_addr(c, REG_WORD_COUNT), data);
                check_value("word count read-back", data, 32'(STEP_WORDS[s][c]));
            end
        end
        for (int c = 0; c < NUM_OF_BOARD; c++) begin
            if (STEP_WORDS[s][c] != 0) begin
                bus_write(reg_addr(c, REG_START_STATUS), 32'd1);
                target[c] += STEP_WORDS[s][c];
            end
        end
        if (STEP_RESEND[s] >= 0) begin
            // Let the first word land so that a wrong restart would move the index
            base_writes = target[STEP_RESEND[s]] - STEP_WORDS[s][STEP_RESEND[s]];
            while (writes[STEP_RESEND[s]] == base_writes) begin
                @(negedge aclk);
            end
            bus_write(reg_addr(STEP_RESEND[s], REG_START_STATUS), 32'd1);
        end
        for (int c = 0; c < NUM_OF_BOARD; c++) begin
            if (STEP_WORDS[s][c] != 0) begin
                bus_read(reg_addr(c, REG_START_STATUS), data);
                check_value("busy while running", data, 32'd1);
                check_lines(c, 1'b0);
            end
        end
        while (!all_written()) begin
            @(negedge aclk);
        end
        repeat (SETTLE_CYCLES) @(negedge aclk);
        for (int c = 0; c < NUM_OF_BOARD; c++) begin
            check_value($sformatf("BRAM writes of channel %0d", c), writes[c], target[c]);
            if (STEP_WORDS[s][c] != 0) begin
                bus_read(reg_addr(c, REG_START_STATUS), data);
                check_value("busy after run", data, 32'd0);
                check_lines(c, 1'b1);
            end
        end
    endtask

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles > timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        timeout_cycles = run_limit();
        up_wreq        = 1'b0;
        up_waddr       = '0;
        up_wdata       = '0;
        up_rreq        = 1'b0;
        up_raddr       = '0;
        rst_n          = 1'b0;
        for (int c = 0; c < NUM_OF_BOARD; c++) begin
            target[c] = 0;
        end
        repeat (RESET_CYCLES) @(negedge aclk);
        rst_n = 1'b1;
        check_quiet_after_reset();
        check_register_access();
        for (int s = 0; s < NUM_STEPS; s++) begin
            run_step(s);
        end
        $display("Checks: %0d, bench errors: %0d, checker errors: %0d, BRAM writes: %0d",
                 checks, errors, checker_errors, writes[0] + writes[1]);
        if (errors == 0 && checker_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
source/ad7124_pkg.sv
source/sample_stream_if.sv
source/ad7124_regmap.sv
source/ad7124_spi_reader.sv
source/sample_fifo.sv
source/bram_packer.sv
source/ad7124_acq_top.sv
bench/tb_clock.sv
bench/tb_bram_checker.sv
bench/tb_ad7124_acq.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_ad7124_acq
RTL_TOP    := ad7124_acq_top
FILE_LIST  := files.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
